//--- rtl/up_gt_cfg.svh
// register map constants of the transceiver pll configuration bridge
// block select, per-channel slot offsets and the transceiver-type word

`ifndef UP_GT_CFG_SVH
`define UP_GT_CFG_SVH

// **************************************************
// block select
// **************************************************

// address bits 13:8 that pick this register block
`define UP_GT_BLOCK_SEL   6'h10

// **************************************************
// channel slots
// **************************************************

// channel 0 command and status offsets
`define UP_GT_CMD_OFS     8'h14
`define UP_GT_STAT_OFS    8'h15

// each further channel sits one stride higher
`define UP_GT_CHAN_STRIDE 8'h10

// slot offsets of channel k before the cast to the offset type
`define UP_GT_CMD_SLOT(k)  (`UP_GT_CMD_OFS + (k) * `UP_GT_CHAN_STRIDE)
`define UP_GT_STAT_SLOT(k) (`UP_GT_STAT_OFS + (k) * `UP_GT_CHAN_STRIDE)

// room in the map for this many channels
`define UP_GT_MAX_CHAN    4

// **************************************************
// transceiver type
// **************************************************

`define UP_GT_TYPE_OFS    8'h3a
// 0 means gtx and 1 means gth
`define UP_GT_TYPE_VAL    32'h00000001

`endif

//--- rtl/up_bus_pkg.sv
// processor register bus types
// 14-bit word address split into block select and offset, 32-bit data

package up_bus_pkg;

  // **************************************************
  // address and data
  // **************************************************

  // full register address, bits 13:8 select the block
  typedef logic [13:0] up_addr_t;

  // register data, both directions
  typedef logic [31:0] up_data_t;

  // register offset inside one block
  typedef logic [7:0]  up_ofs_t;

  // block select field
  typedef logic [5:0]  up_blk_t;

  // **************************************************
  // address fields
  // **************************************************

  // upper part, compared against the block select
  function automatic up_blk_t up_addr_blk(input up_addr_t addr);
    return addr[13:8];
  endfunction

  // lower part, picks the register inside the block
  function automatic up_ofs_t up_addr_ofs(input up_addr_t addr);
    return addr[7:0];
  endfunction

endpackage

//--- rtl/drp_pkg.sv
// dynamic reconfiguration port types
// drp address and data plus the packed command word of one access

package drp_pkg;

  // **************************************************
  // drp port
  // **************************************************

  // 12-bit drp register address
  typedef logic [11:0] drp_addr_t;

  // 16-bit drp data, write and read
  typedef logic [15:0] drp_data_t;

  // **************************************************
  // command word
  // **************************************************

  // layout of bits 28:0 of a command register write
  //   28    read-not-write
  //   27:16 drp address
  //   15:0  write data, don't care for reads
  typedef struct packed {
    // 1 reads, 0 writes
    logic      rwn;
    // target register
    drp_addr_t addr;
    // value for a write
    drp_data_t wdata;
  } drp_cmd_t;

endpackage

//--- rtl/up_gt_decode.sv
// write-side decode of the transceiver pll configuration block
// checks block select and offset once, acks the write and hands the
// command word to the channel whose command slot was hit

`timescale 1ns/10ps

`include "up_gt_cfg.svh"

module up_gt_decode import up_bus_pkg::*, drp_pkg::*; #(
  parameter int n_chan = 2
) (
  input  logic              up_clk,
  input  logic              up_rstn,

  // processor write port
  input  logic              up_wreq,
  input  up_addr_t          up_waddr,
  input  up_data_t          up_wdata,
  output logic              up_wack,

  // one strobe per channel, shared command word
  output logic [n_chan-1:0] cmd_load,
  output drp_cmd_t          cmd
);

  // write request that belongs to this block
  logic              wreq_s;
  // offset of the current write
  up_ofs_t           wofs;
  // command slot hit, one bit per channel
  logic [n_chan-1:0] load_s;

  // **************************************************
  // address decode
  // **************************************************

  assign wreq_s = up_wreq & (up_addr_blk(up_waddr) == `UP_GT_BLOCK_SEL);
  assign wofs   = up_addr_ofs(up_waddr);

  // at most one slot matches, status slots are read-only
  always_comb begin
    for (int k = 0; k < n_chan; k++) begin
      load_s[k] = wreq_s & (wofs == up_ofs_t'(`UP_GT_CMD_SLOT(k)));
    end
  end

  // **************************************************
  // registered outputs
  // **************************************************

  // ack any write in the block, even to offsets with nothing behind them
  always_ff @(posedge up_clk) begin
    if (up_rstn == 1'b0) begin
      up_wack  <= 1'b0;
      cmd_load <= '0;
    end else begin
      up_wack  <= wreq_s;
      // single-cycle strobe
      cmd_load <= load_s;
    end
  end

  // command word lines up with cmd_load
  always_ff @(posedge up_clk) begin
    if (wreq_s == 1'b1) begin
      // bits 31:29 of the write are unused
      cmd <= drp_cmd_t'(up_wdata[28:0]);
    end
  end

endmodule

//--- rtl/up_drp_chan.sv
// one qpll channel of the configuration bridge
// holds the last command, launches one drp access per load and keeps
// the data the drp returns, busy covers the access

`timescale 1ns/10ps

module up_drp_chan import drp_pkg::*; (
  input  logic      up_clk,
  input  logic      up_rstn,

  // command from the write decoder
  input  logic      cmd_load,
  input  drp_cmd_t  cmd,

  // register levels for the read side
  output drp_cmd_t  cmd_q,
  output logic      busy,
  output drp_data_t rdata_q,

  // drp master port
  output logic      drp_sel,
  output logic      drp_wr,
  output drp_addr_t drp_addr,
  output drp_data_t drp_wdata,
  input  drp_data_t drp_rdata,
  input  logic      drp_ready
);

  // **************************************************
  // command hold and drp strobes
  // **************************************************

  // sel and wr last exactly one cycle after each load
  always_ff @(posedge up_clk) begin
    if (up_rstn == 1'b0) begin
      drp_sel <= 1'b0;
      drp_wr  <= 1'b0;
      cmd_q   <= '0;
    end else begin
      drp_sel <= cmd_load;
      // wr only for rwn low
      drp_wr  <= cmd_load & ~cmd.rwn;
      if (cmd_load == 1'b1) begin
        cmd_q <= cmd;
      end
    end
  end

  // address and data come straight from the held command,
  // so they are valid in the sel cycle and stay afterwards
  assign drp_addr  = cmd_q.addr;
  assign drp_wdata = cmd_q.wdata;

  // **************************************************
  // access tracking
  // **************************************************

  // a load during an open access starts over,
  // load wins over a ready in the same cycle
  always_ff @(posedge up_clk) begin
    if (up_rstn == 1'b0) begin
      busy <= 1'b0;
    end else if (cmd_load == 1'b1) begin
      busy <= 1'b1;
    end else if (drp_ready == 1'b1) begin
      busy <= 1'b0;
    end
  end

  // return data
  // captured on the same edge that drops busy,
  // writes return data too and overwrite it
  always_ff @(posedge up_clk) begin
    if (up_rstn == 1'b0) begin
      rdata_q <= '0;
    end else if (drp_ready == 1'b1) begin
      rdata_q <= drp_rdata;
    end
  end

endmodule

//--- rtl/up_gt_rdata.sv
// read-side decode of the transceiver pll configuration block
// multiplexes channel command and status registers and the type word
// onto read data, with a one-cycle read acknowledge

`timescale 1ns/10ps

`include "up_gt_cfg.svh"

module up_gt_rdata import up_bus_pkg::*, drp_pkg::*; #(
  parameter int n_chan = 2
) (
  input  logic              up_clk,
  input  logic              up_rstn,

  // processor read port
  input  logic              up_rreq,
  input  up_addr_t          up_raddr,
  output up_data_t          up_rdata,
  output logic              up_rack,

  // channel register levels
  input  drp_cmd_t          cmd_q   [n_chan],
  input  logic [n_chan-1:0] busy,
  input  drp_data_t         rdata_q [n_chan]
);

  logic      rreq_s;
  up_ofs_t   rofs;
  up_data_t  rdata_s;

  // every slot of the map, absent channels tied to zero
  drp_cmd_t                  cmd_slot   [`UP_GT_MAX_CHAN];
  logic [`UP_GT_MAX_CHAN-1:0] busy_slot;
  drp_data_t                 rdata_slot [`UP_GT_MAX_CHAN];

  assign rreq_s = up_rreq & (up_addr_blk(up_raddr) == `UP_GT_BLOCK_SEL);
  assign rofs   = up_addr_ofs(up_raddr);

  for (genvar k = 0; k < `UP_GT_MAX_CHAN; k++) begin : g_slot
    if (k < n_chan) begin : g_used
      assign cmd_slot[k]   = cmd_q[k];
      assign busy_slot[k]  = busy[k];
      assign rdata_slot[k] = rdata_q[k];
    end else begin : g_absent
      assign cmd_slot[k]   = '0;
      assign busy_slot[k]  = 1'b0;
      assign rdata_slot[k] = '0;
    end
  end

  // **************************************************
  // register select
  // **************************************************

  // unknown offsets read zero
  always_comb begin
    rdata_s = '0;
    if (rofs == up_ofs_t'(`UP_GT_TYPE_OFS)) begin
      rdata_s = `UP_GT_TYPE_VAL;
    end
    for (int k = 0; k < `UP_GT_MAX_CHAN; k++) begin
      // command readback, upper bits zero
      if (rofs == up_ofs_t'(`UP_GT_CMD_SLOT(k))) begin
        rdata_s = up_data_t'(cmd_slot[k]);
      end
      // busy at 16, last drp data below
      if (rofs == up_ofs_t'(`UP_GT_STAT_SLOT(k))) begin
        rdata_s = {15'd0, busy_slot[k], rdata_slot[k]};
      end
    end
  end

  // data only in the ack cycle, zero otherwise
  always_ff @(posedge up_clk) begin
    if (up_rstn == 1'b0) begin
      up_rack  <= 1'b0;
      up_rdata <= '0;
    end else begin
      up_rack  <= rreq_s;
      up_rdata <= (rreq_s == 1'b1) ? rdata_s : '0;
    end
  end

endmodule

//--- rtl/up_gt.sv
// transceiver pll configuration bridge, top level
// write decoder, one drp channel per qpll and the read-return mux
// n_chan from 1 to 4

`timescale 1ns/10ps

module up_gt import up_bus_pkg::*, drp_pkg::*; #(
  parameter int n_chan = 2
) (
  input  logic              up_clk,
  input  logic              up_rstn,

  // processor write port
  input  logic              up_wreq,
  input  up_addr_t          up_waddr,
  input  up_data_t          up_wdata,
  output logic              up_wack,

  // processor read port
  input  logic              up_rreq,
  input  up_addr_t          up_raddr,
  output up_data_t          up_rdata,
  output logic              up_rack,

  // drp ports, index k serves qpll k
  output logic [n_chan-1:0] drp_sel,
  output logic [n_chan-1:0] drp_wr,
  output drp_addr_t         drp_addr  [n_chan],
  output drp_data_t         drp_wdata [n_chan],
  input  drp_data_t         drp_rdata [n_chan],
  input  logic [n_chan-1:0] drp_ready
);

  // decoder to channels
  logic [n_chan-1:0] cmd_load;
  drp_cmd_t          cmd;

  // channels to read mux
  drp_cmd_t          cmd_q   [n_chan];
  logic [n_chan-1:0] busy;
  drp_data_t         rdata_q [n_chan];

  // **************************************************
  // write side
  // **************************************************

  up_gt_decode #(
    .n_chan   (n_chan)
  ) i_decode (
    .up_clk   (up_clk),
    .up_rstn  (up_rstn),
    .up_wreq  (up_wreq),
    .up_waddr (up_waddr),
    .up_wdata (up_wdata),
    .up_wack  (up_wack),
    .cmd_load (cmd_load),
    .cmd      (cmd)
  );

  // **************************************************
  // channels
  // **************************************************

  for (genvar k = 0; k < n_chan; k++) begin : g_chan
    up_drp_chan i_chan (
      .up_clk    (up_clk),
      .up_rstn   (up_rstn),
      .cmd_load  (cmd_load[k]),
      .cmd       (cmd),
      .cmd_q     (cmd_q[k]),
      .busy      (busy[k]),
      .rdata_q   (rdata_q[k]),
      .drp_sel   (drp_sel[k]),
      .drp_wr    (drp_wr[k]),
      .drp_addr  (drp_addr[k]),
      .drp_wdata (drp_wdata[k]),
      .drp_rdata (drp_rdata[k]),
      .drp_ready (drp_ready[k])
    );
  end

  // read side
  up_gt_rdata #(
    .n_chan   (n_chan)
  ) i_rdata (
    .up_clk   (up_clk),
    .up_rstn  (up_rstn),
    .up_rreq  (up_rreq),
    .up_raddr (up_raddr),
    .up_rdata (up_rdata),
    .up_rack  (up_rack),
    .cmd_q    (cmd_q),
    .busy     (busy),
    .rdata_q  (rdata_q)
  );

endmodule

//--- tb/drp_slave_model.sv
// behavioral drp slave for one qpll channel
// 4096-word register memory, answers every access with one ready pulse
// after a random latency of 1 to 4 cycles

`timescale 1ns/10ps

module drp_slave_model import drp_pkg::*; (
  input  logic      up_clk,
  input  logic      up_rstn,

  // drp slave port
  input  logic      drp_sel,
  input  logic      drp_wr,
  input  drp_addr_t drp_addr,
  input  drp_data_t drp_wdata,
  output drp_data_t drp_rdata,
  output logic      drp_ready
);

  // register file behind the port
  drp_data_t mem [4096];

  // access in flight
  drp_addr_t pend_addr = '0;
  int        wait_cnt  = 0;

  // outputs start low before the first reset edge
  logic      ready_q   = 1'b0;
  drp_data_t rdata_q   = '0;

  assign drp_ready = ready_q;
  assign drp_rdata = rdata_q;

  // **************************************************
  // access handling
  // **************************************************

  always @(posedge up_clk) begin
    if (up_rstn == 1'b0) begin
      ready_q   <= 1'b0;
      rdata_q   <= '0;
      wait_cnt  <= 0;
      pend_addr <= '0;
      // fill tracks the whole address
      for (int a = 0; a < 4096; a++) begin
        mem[a] <= {~a[3:0], a[11:0]};
      end
    end else begin
      ready_q <= 1'b0;
      if (drp_sel == 1'b1) begin
        // a new select restarts any open access
        if (drp_wr == 1'b1) begin
          mem[drp_addr] <= drp_wdata;
        end
        pend_addr <= drp_addr;
        wait_cnt  <= int'($urandom % 4) + 1;
      end else if (wait_cnt == 1) begin
        // writes return the new value too
        ready_q  <= 1'b1;
        rdata_q  <= mem[pend_addr];
        wait_cnt <= 0;
      end else if (wait_cnt > 1) begin
        wait_cnt <= wait_cnt - 1;
      end
    end
  end

endmodule

//--- tb/tb_up_gt.sv
// testbench of the transceiver pll configuration bridge
// table of register accesses and drp commands, two drp slave models,
// strobe counters at the dut ports and a shadow of each slave memory

`timescale 1ns/10ps

`include "up_gt_cfg.svh"

module tb_up_gt import up_bus_pkg::*, drp_pkg::*;;

  localparam int n_chan      = 2;
  localparam int ack_timeout = 8;
  localparam int poll_limit  = 32;

  typedef enum {OP_RD, OP_WR, OP_RD_NA, OP_WR_NA, OP_CMD} op_t;

  logic              up_clk;
  logic              up_rstn;
  logic              up_wreq;
  up_addr_t          up_waddr;
  up_data_t          up_wdata;
  logic              up_wack;
  logic              up_rreq;
  up_addr_t          up_raddr;
  up_data_t          up_rdata;
  logic              up_rack;
  logic [n_chan-1:0] drp_sel;
  logic [n_chan-1:0] drp_wr;
  drp_addr_t         drp_addr  [n_chan];
  drp_data_t         drp_wdata [n_chan];
  drp_data_t         drp_rdata [n_chan];
  logic [n_chan-1:0] drp_ready;

  // strobes seen at the dut ports
  int        sel_cnt    [n_chan] = '{default: 0};
  int        wr_cnt     [n_chan] = '{default: 0};
  drp_addr_t seen_addr  [n_chan] = '{default: '0};
  drp_data_t seen_wdata [n_chan] = '{default: '0};

  // expected slave memories
  drp_data_t shadow [n_chan][4096];

  // stimulus table with one entry per row in each queue
  string    names [$];
  op_t      ops   [$];
  up_addr_t addrs [$];
  up_data_t datas [$];
  up_data_t exps  [$];

  up_gt #(
    .n_chan    (n_chan)
  ) i_up_gt (
    .up_clk    (up_clk),
    .up_rstn   (up_rstn),
    .up_wreq   (up_wreq),
    .up_waddr  (up_waddr),
    .up_wdata  (up_wdata),
    .up_wack   (up_wack),
    .up_rreq   (up_rreq),
    .up_raddr  (up_raddr),
    .up_rdata  (up_rdata),
    .up_rack   (up_rack),
    .drp_sel   (drp_sel),
    .drp_wr    (drp_wr),
    .drp_addr  (drp_addr),
    .drp_wdata (drp_wdata),
    .drp_rdata (drp_rdata),
    .drp_ready (drp_ready)
  );

  for (genvar k = 0; k < n_chan; k++) begin : g_slave
    drp_slave_model i_slave (
      .up_clk    (up_clk),
      .up_rstn   (up_rstn),
      .drp_sel   (drp_sel[k]),
      .drp_wr    (drp_wr[k]),
      .drp_addr  (drp_addr[k]),
      .drp_wdata (drp_wdata[k]),
      .drp_rdata (drp_rdata[k]),
      .drp_ready (drp_ready[k])
    );
  end

  initial begin
    up_clk = 1'b0;
    forever #5 up_clk = ~up_clk;
  end

  // strobes are stable mid-cycle
  always @(negedge up_clk) begin
    for (int k = 0; k < n_chan; k++) begin
      if (drp_sel[k] === 1'b1) begin
        sel_cnt[k]    <= sel_cnt[k] + 1;
        seen_addr[k]  <= drp_addr[k];
        seen_wdata[k] <= drp_wdata[k];
        if (drp_wr[k] === 1'b1) begin
          wr_cnt[k] <= wr_cnt[k] + 1;
        end
      end
    end
  end

  // **************************************************
  // addresses and command words
  // **************************************************

  function automatic up_addr_t blk_addr(input up_ofs_t ofs);
    return {`UP_GT_BLOCK_SEL, ofs};
  endfunction

  function automatic up_addr_t cmd_addr(input int k);
    return blk_addr(up_ofs_t'(`UP_GT_CMD_SLOT(k)));
  endfunction

  function automatic up_addr_t stat_addr(input int k);
    return blk_addr(up_ofs_t'(`UP_GT_STAT_SLOT(k)));
  endfunction

  // rwn at 28, address 27:16, data 15:0
  function automatic up_data_t cmd_word(input logic rwn, input drp_addr_t a,
                                        input drp_data_t d);
    return {3'b000, rwn, a, d};
  endfunction

  // **************************************************
  // reporting and checks
  // **************************************************

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("Verification failed");
    $fatal(1, "simulation stopped on the first error");
  endtask

  task automatic check_data(input string name, input up_data_t exp, input up_data_t act);
    if (act !== exp) begin
      fail_run($sformatf("ERROR %s expected 0x%08h actual 0x%08h", name, exp, act));
    end
  endtask

  task automatic check_drp(input string name, input drp_data_t exp, input drp_data_t act);
    if (act !== exp) begin
      fail_run($sformatf("ERROR %s expected 0x%04h actual 0x%04h", name, exp, act));
    end
  endtask

  // ack due one cycle after the request
  task automatic expect_ack(input string name, input int lat);
    if (lat < 0) begin
      fail_run($sformatf("%s got no acknowledge within %0d cycles", name, ack_timeout));
    end else if (lat != 1) begin
      fail_run($sformatf("%s was acknowledged after %0d cycles instead of 1", name, lat));
    end
  endtask

  task automatic expect_no_ack(input string name, input int lat);
    if (lat >= 0) begin
      fail_run($sformatf("%s was acknowledged outside the block select", name));
    end
  endtask

  // **************************************************
  // bus tasks entered and left on a falling edge
  // **************************************************

  task automatic bus_write(input up_addr_t addr, input up_data_t data, output int lat);
    up_wreq  = 1'b1;
    up_waddr = addr;
    up_wdata = data;
    @(negedge up_clk);
    up_wreq = 1'b0;
    lat     = 1;
    while (up_wack !== 1'b1 && lat < ack_timeout) begin
      @(negedge up_clk);
      lat++;
    end
    if (up_wack !== 1'b1) begin
      lat = -1;
    end
  endtask

  task automatic bus_read(input up_addr_t addr, output up_data_t data, output int lat);
    up_rreq  = 1'b1;
    up_raddr = addr;
    @(negedge up_clk);
    up_rreq = 1'b0;
    lat     = 1;
    while (up_rack !== 1'b1 && lat < ack_timeout) begin
      @(negedge up_clk);
      lat++;
    end
    // read data only valid in the ack cycle
    data = up_rdata;
    if (up_rack !== 1'b1) begin
      lat = -1;
    end
  endtask

  // poll status until busy drops
  // first poll lands before ready
  task automatic poll_idle(input string name, input int k, output up_data_t stat);
    int polls;
    int lat;
    polls = 0;
    @(negedge up_clk);
    bus_read(stat_addr(k), stat, lat);
    expect_ack({name, " status poll"}, lat);
    check_data({name, " busy before ready"}, up_data_t'(1), up_data_t'(stat[16]));
    while (stat[16] == 1'b1 && polls < poll_limit) begin
      bus_read(stat_addr(k), stat, lat);
      expect_ack({name, " status poll"}, lat);
      polls++;
    end
    if (stat[16] == 1'b1) begin
      fail_run($sformatf("%s left channel %0d busy after %0d polls", name, k, polls));
    end
  endtask

  // one drp access through the command register
  task automatic run_cmd(input string name, input up_addr_t addr, input up_data_t data);
    int        k;
    int        sel0;
    int        wr0;
    int        lat;
    logic      rwn;
    drp_addr_t a;
    drp_data_t d;
    up_data_t  stat;
    k    = int'((addr[7:0] - `UP_GT_CMD_OFS) / `UP_GT_CHAN_STRIDE);
    rwn  = data[28];
    a    = data[27:16];
    d    = data[15:0];
    sel0 = sel_cnt[k];
    wr0  = wr_cnt[k];
    bus_write(addr, data, lat);
    expect_ack(name, lat);
    poll_idle(name, k, stat);
    if (rwn == 1'b0) begin
      shadow[k][a] = d;
    end
    check_data({name, " sel pulses"}, up_data_t'(1), up_data_t'(sel_cnt[k] - sel0));
    check_data({name, " wr pulses"}, up_data_t'(rwn ? 0 : 1), up_data_t'(wr_cnt[k] - wr0));
    check_drp({name, " drp addr"}, drp_data_t'(a), drp_data_t'(seen_addr[k]));
    if (rwn == 1'b0) begin
      check_drp({name, " drp wdata"}, d, seen_wdata[k]);
    end
    check_drp({name, " status data"}, shadow[k][a], stat[15:0]);
  endtask

  // **************************************************
  // stimulus table
  // **************************************************

  task automatic add_row(input string name, input op_t op, input up_addr_t addr,
                         input up_data_t data, input up_data_t exp);
    names.push_back(name);
    ops.push_back(op);
    addrs.push_back(addr);
    datas.push_back(data);
    exps.push_back(exp);
  endtask

  task automatic build_table();
    add_row("type word", OP_RD, blk_addr(`UP_GT_TYPE_OFS), 32'h0, `UP_GT_TYPE_VAL);
    for (int k = 0; k < n_chan; k++) begin
      add_row($sformatf("reset cmd%0d", k), OP_RD, cmd_addr(k), 32'h0, 32'h0);
      add_row($sformatf("reset stat%0d", k), OP_RD, stat_addr(k), 32'h0, 32'h0);
    end
    add_row("wr ch0 a123", OP_CMD, cmd_addr(0), cmd_word(1'b0, 12'h123, 16'hbeef), 32'h0);
    add_row("cmd0 readback", OP_RD, cmd_addr(0), 32'h0, cmd_word(1'b0, 12'h123, 16'hbeef));
    add_row("rd ch0 a123", OP_CMD, cmd_addr(0), cmd_word(1'b1, 12'h123, 16'h0000), 32'h0);
    // bits 31:29 set and must not come back
    add_row("wr ch1 a045", OP_CMD, cmd_addr(1),
            32'he000_0000 | cmd_word(1'b0, 12'h045, 16'h1234), 32'h0);
    add_row("cmd1 readback", OP_RD, cmd_addr(1), 32'h0, cmd_word(1'b0, 12'h045, 16'h1234));
    add_row("wr ch0 a045", OP_CMD, cmd_addr(0), cmd_word(1'b0, 12'h045, 16'h5678), 32'h0);
    add_row("rd ch1 a045", OP_CMD, cmd_addr(1), cmd_word(1'b1, 12'h045, 16'h0000), 32'h0);
    add_row("rd ch0 a045", OP_CMD, cmd_addr(0), cmd_word(1'b1, 12'h045, 16'h0000), 32'h0);
    add_row("stat1 own data", OP_RD, stat_addr(1), 32'h0, 32'h0000_1234);
    add_row("stat0 own data", OP_RD, stat_addr(0), 32'h0, 32'h0000_5678);
    add_row("rd ch1 a7ff", OP_CMD, cmd_addr(1), cmd_word(1'b1, 12'h7ff, 16'h0000), 32'h0);
    // neighbour blocks
    add_row("wr other block", OP_WR_NA, up_addr_t'({6'h11, 8'h14}),
            cmd_word(1'b0, 12'h001, 16'h0bad), 32'h0);
    add_row("rd other block", OP_RD_NA, up_addr_t'({6'h00, 8'h3a}), 32'h0, 32'h0);
    add_row("cmd0 unchanged", OP_RD, cmd_addr(0), 32'h0, cmd_word(1'b1, 12'h045, 16'h0000));
    // holes inside the block
    add_row("rd unused 00", OP_RD, blk_addr(8'h00), 32'h0, 32'h0);
    add_row("rd unused 16", OP_RD, blk_addr(8'h16), 32'h0, 32'h0);
    add_row("rd absent cmd2", OP_RD, blk_addr(up_ofs_t'(`UP_GT_CMD_SLOT(2))), 32'h0, 32'h0);
    add_row("wr unused 20", OP_WR, blk_addr(8'h20), 32'h1234_5678, 32'h0);
  endtask

  task automatic apply_row(input int i);
    up_data_t rd;
    int       lat;
    case (ops[i])
      OP_RD: begin
        bus_read(addrs[i], rd, lat);
        expect_ack(names[i], lat);
        check_data(names[i], exps[i], rd);
      end
      OP_WR: begin
        bus_write(addrs[i], datas[i], lat);
        expect_ack(names[i], lat);
      end
      OP_RD_NA: begin
        bus_read(addrs[i], rd, lat);
        expect_no_ack(names[i], lat);
        // read data stays zero without an ack
        check_data(names[i], exps[i], rd);
      end
      OP_WR_NA: begin
        bus_write(addrs[i], datas[i], lat);
        expect_no_ack(names[i], lat);
      end
      default: begin
        run_cmd(names[i], addrs[i], datas[i]);
      end
    endcase
  endtask

  // **************************************************
  // main sequence
  // **************************************************

  initial begin
    up_rstn  = 1'b0;
    up_wreq  = 1'b0;
    up_waddr = '0;
    up_wdata = '0;
    up_rreq  = 1'b0;
    up_raddr = '0;
    void'($urandom(5));
    // same fill as the slave memories
    for (int k = 0; k < n_chan; k++) begin
      for (int a = 0; a < 4096; a++) begin
        shadow[k][a] = {~a[3:0], a[11:0]};
      end
    end
    build_table();
    repeat (8) @(posedge up_clk);
    @(negedge up_clk);
    up_rstn = 1'b1;
    repeat (2) @(negedge up_clk);
    for (int i = 0; i < names.size(); i++) begin
      apply_row(i);
    end
    $display("Verification passed");
    $finish;
  end

endmodule

//--- vlog.f
+incdir+rtl
rtl/up_bus_pkg.sv
rtl/drp_pkg.sv
rtl/up_gt_decode.sv
rtl/up_drp_chan.sv
rtl/up_gt_rdata.sv
rtl/up_gt.sv
tb/drp_slave_model.sv
tb/tb_up_gt.sv

//--- run_sim.sh
#!/bin/sh
# build the testbench with verilator and run it
# exit status is nonzero on a build error or a failed run

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f vlog.f --top-module tb_up_gt -Mdir obj_dir \
  && ./obj_dir/Vtb_up_gt \
  || { echo "simulation did not pass"; exit 1; }
